// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f rv_mem.f \
    --top-module tb_mem_subsystem --Mdir obj_dir -o tb_mem_subsystem || exit 1

out=$(./obj_dir/tb_mem_subsystem)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// File: rv_mem.f
src/rv_mem_pkg.sv
src/rv_mem_ifs.sv
src/store_align.sv
src/load_reduce.sv
src/data_mem.sv
src/memory_stage.sv
src/writeback_stage.sv
src/mem_subsystem_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_subsystem.sv

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // Free-running clock, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    // Cycle budget summed over the reset, word, narrow, forwarding, stall and read-back tests
    localparam int STIM_CYCLES = 16 + 40 + 40 + 16 + 100 + 40;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

    logic                    clk_i;
    logic                    rst_i;
    logic                    in_valid_i;
    logic                    in_ready_o;
    logic [31:0]             in_alu_result_i;
    logic [31:0]             in_write_data_i;
    logic [31:0]             in_pc_target_i;
    logic [31:0]             in_pc_plus4_i;
    logic [31:0]             in_imm_ext_i;
    logic [4:0]              in_rd_i;
    rv_mem_pkg::width_src_e  in_width_src_i;
    rv_mem_pkg::result_src_e in_result_src_i;
    logic                    in_mem_write_i;
    logic                    in_reg_write_i;
    logic                    fwd_valid_o;
    logic [4:0]              fwd_rd_o;
    logic [31:0]             fwd_data_o;
    logic                    wb_valid_o;
    logic                    wb_ready_i = 1'b1;
    logic [4:0]              wb_rd_o;
    logic [31:0]             wb_data_o;
    logic                    wb_reg_write_o;

    logic [7:0]  mem_model [0:1023];
    logic [31:0] exp_data [$];
    logic [4:0]  exp_rd [$];
    logic        exp_rw [$];
    int          exp_cycle [$];
    logic [15:0] lfsr_state = 16'd47;
    logic [31:0] ready_pattern;
    logic        stall_mode = 1'b0;
    logic        fixed_timing = 1'b0;
    int          cycle_cnt = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "none";

    tb_clock_gen #(.PERIOD_NS(40)) tb_clock_gen_inst (.clk_o(clk_i));

    mem_subsystem_top #(.MEM_DEPTH_WORDS(256)) mem_subsystem_top_inst (.*);

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic rv_mem_pkg::width_src_e pick_width(logic [2:0] n);
        case (n)
            3'd0:    return rv_mem_pkg::WIDTH_B;
            3'd1:    return rv_mem_pkg::WIDTH_H;
            3'd3:    return rv_mem_pkg::WIDTH_BU;
            3'd4:    return rv_mem_pkg::WIDTH_HU;
            default: return rv_mem_pkg::WIDTH_W;
        endcase
    endfunction

    function automatic rv_mem_pkg::result_src_e pick_src(logic [1:0] n);
        case (n)
            2'd0:    return rv_mem_pkg::RESULT_ALU;
            2'd1:    return rv_mem_pkg::RESULT_PCTARGET;
            2'd2:    return rv_mem_pkg::RESULT_PCPLUS4;
            default: return rv_mem_pkg::RESULT_IMM_EXT;
        endcase
    endfunction

    // Natural alignment for the access width
    function automatic logic [1:0] aligned_offset(rv_mem_pkg::width_src_e width, logic [1:0] r);
        if (width == rv_mem_pkg::WIDTH_B || width == rv_mem_pkg::WIDTH_BU) begin
            return r;
        end else if (width == rv_mem_pkg::WIDTH_H || width == rv_mem_pkg::WIDTH_HU) begin
            return {r[1], 1'b0};
        end
        return 2'd0;
    endfunction

    function automatic logic [31:0] fill_value(logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    // Little-endian byte-array memory model
    function automatic void model_store(logic [31:0] addr, rv_mem_pkg::width_src_e width,
                                        logic [31:0] data);
        int a;
        a = int'(addr[9:0]);
        mem_model[a] = data[7:0];
        if (width == rv_mem_pkg::WIDTH_H || width == rv_mem_pkg::WIDTH_HU) begin
            mem_model[a + 1] = data[15:8];
        end else if (width == rv_mem_pkg::WIDTH_W) begin
            for (int k = 1; k < 4; k++) begin
                mem_model[a + k] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_load(logic [31:0] addr, rv_mem_pkg::width_src_e width);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        a = int'(addr[9:0]);
        b = mem_model[a];
        h = {mem_model[a | 1], b};
        case (width)
            rv_mem_pkg::WIDTH_B:  return {{24{b[7]}}, b};
            rv_mem_pkg::WIDTH_BU: return {24'h0, b};
            rv_mem_pkg::WIDTH_H:  return {{16{h[15]}}, h};
            rv_mem_pkg::WIDTH_HU: return {16'h0, h};
            default:              return {mem_model[a + 3], mem_model[a + 2], h};
        endcase
    endfunction

    // Drive one item, wait for the handshake, queue its expected result
    task automatic send_item(input logic [31:0] alu, input logic [31:0] wdata,
                             input logic [4:0] rd, input rv_mem_pkg::width_src_e width,
                             input rv_mem_pkg::result_src_e src, input logic mem_write,
                             input logic reg_write, output logic [31:0] expv);
        logic [31:0] pct;
        logic [31:0] pcp;
        logic [31:0] imm;
        pct = rand_bits(32);
        pcp = rand_bits(32);
        imm = rand_bits(32);
        if (mem_write) begin
            model_store(alu, width, wdata);
        end
        case (src)
            rv_mem_pkg::RESULT_MEM:      expv = model_load(alu, width);
            rv_mem_pkg::RESULT_PCTARGET: expv = pct;
            rv_mem_pkg::RESULT_PCPLUS4:  expv = pcp;
            rv_mem_pkg::RESULT_IMM_EXT:  expv = imm;
            default:                     expv = alu;
        endcase
        @(posedge clk_i);
        in_valid_i      <= 1'b1;
        in_alu_result_i <= alu;
        in_write_data_i <= wdata;
        in_pc_target_i  <= pct;
        in_pc_plus4_i   <= pcp;
        in_imm_ext_i    <= imm;
        in_rd_i         <= rd;
        in_width_src_i  <= width;
        in_result_src_i <= src;
        in_mem_write_i  <= mem_write;
        in_reg_write_i  <= reg_write;
        @(negedge clk_i);
        while (!in_ready_o) begin
            @(negedge clk_i);
        end
        exp_data.push_back(expv);
        exp_rd.push_back(rd);
        exp_rw.push_back(reg_write);
        exp_cycle.push_back(cycle_cnt);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        idle_cycle();
        while (exp_data.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    // Loads of every width at every aligned offset of one word
    task automatic load_sweep(input logic [31:0] base);
        rv_mem_pkg::width_src_e width;
        logic [31:0]            expv;
        logic [31:0]            r;
        for (int w = 0; w < 5; w++) begin
            width = pick_width(3'(w));
            for (int off = 0; off < 4; off++) begin
                if (aligned_offset(width, 2'(off)) == 2'(off)) begin
                    r = rand_bits(5);
                    send_item(base + 32'(off), 32'h0, r[4:0], width,
                              rv_mem_pkg::RESULT_MEM, 1'b0, 1'b1, expv);
                end
            end
        end
    endtask

    task automatic check_reset_state();
        assert (!wb_valid_o && !fwd_valid_o && in_ready_o) else begin
            $display("[ERROR] %s: valid/fwd/ready expected 001 actual %b%b%b",
                     cur_test, wb_valid_o, fwd_valid_o, in_ready_o);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (stall_mode) begin
            wb_ready_i <= ready_pattern[cycle_cnt % 32];
        end else begin
            wb_ready_i <= 1'b1;
        end
    end

    // A stalled write-back item must hold still
    assert property (@(posedge clk_i) disable iff (rst_i)
            (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_data_o) && $stable(wb_rd_o)))
        else begin
            $display("%s: write-back output changed while stalled", cur_test);
            errors++;
        end

    // Each transfer is compared with the oldest expected result
    always @(negedge clk_i) begin
        if (!rst_i && wb_valid_o && wb_ready_i) begin
            if (exp_data.size() == 0) begin
                $display("%s: write-back result arrived with none expected", cur_test);
                errors++;
            end else begin
                assert (wb_data_o == exp_data[0]) else begin
                    $display("[ERROR] %s: wb_data expected %h actual %h",
                             cur_test, exp_data[0], wb_data_o);
                    errors++;
                end
                assert (wb_rd_o == exp_rd[0]) else begin
                    $display("[ERROR] %s: wb_rd expected %0d actual %0d",
                             cur_test, exp_rd[0], wb_rd_o);
                    errors++;
                end
                assert (wb_reg_write_o == exp_rw[0]) else begin
                    $display("[ERROR] %s: wb_reg_write expected %b actual %b",
                             cur_test, exp_rw[0], wb_reg_write_o);
                    errors++;
                end
                assert (!fixed_timing || cycle_cnt == exp_cycle[0] + 2) else begin
                    $display("[ERROR] %s: result cycle expected %0d actual %0d",
                             cur_test, exp_cycle[0] + 2, cycle_cnt);
                    errors++;
                end
                void'(exp_data.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_rw.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles in test %s", cycle_cnt, cur_test);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rv_mem_pkg::width_src_e width;
        logic [31:0]            r;
        logic [31:0]            expv;
        logic [31:0]            addr;
        rst_i           <= 1'b1;
        in_valid_i      <= 1'b0;
        in_alu_result_i <= '0;
        in_write_data_i <= '0;
        in_pc_target_i  <= '0;
        in_pc_plus4_i   <= '0;
        in_imm_ext_i    <= '0;
        in_rd_i         <= '0;
        in_width_src_i  <= rv_mem_pkg::WIDTH_W;
        in_result_src_i <= rv_mem_pkg::RESULT_ALU;
        in_mem_write_i  <= 1'b0;
        in_reg_write_i  <= 1'b0;

        start_test("reset");
        repeat (15) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_reset_state();
        end
        @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (2) begin
            @(negedge clk_i);
            check_reset_state();
        end
        end_test();

        start_test("word_store_load");
        fixed_timing = 1'b1;
        for (int w = 0; w < 16; w++) begin
            addr = 32'(w) * 4;
            send_item(addr, fill_value(addr), 5'd0, rv_mem_pkg::WIDTH_W,
                      rv_mem_pkg::RESULT_ALU, 1'b1, 1'b0, expv);
        end
        for (int w = 0; w < 16; w++) begin
            r = rand_bits(5);
            send_item(32'(w) * 4, 32'h0, r[4:0], rv_mem_pkg::WIDTH_W,
                      rv_mem_pkg::RESULT_MEM, 1'b0, 1'b1, expv);
        end
        wait_drain();
        end_test();

        start_test("narrow_access");
        send_item(32'd64, 32'hF07F_8001, 5'd0, rv_mem_pkg::WIDTH_W,
                  rv_mem_pkg::RESULT_ALU, 1'b1, 1'b0, expv);
        load_sweep(32'd64);
        send_item(32'd65, 32'h0000_00C3, 5'd0, rv_mem_pkg::WIDTH_B,
                  rv_mem_pkg::RESULT_ALU, 1'b1, 1'b0, expv);
        send_item(32'd66, 32'h0000_8A5E, 5'd0, rv_mem_pkg::WIDTH_H,
                  rv_mem_pkg::RESULT_ALU, 1'b1, 1'b0, expv);
        load_sweep(32'd64);
        wait_drain();
        end_test();

        start_test("forwarding");
        for (int s = 0; s < 4; s++) begin
            r = rand_bits(32);
            send_item(r, 32'h0, 5'(s + 1), rv_mem_pkg::WIDTH_W, pick_src(2'(s)),
                      1'b0, 1'b1, expv);
            idle_cycle();
            @(negedge clk_i);
            assert (fwd_valid_o && fwd_rd_o == 5'(s + 1) && fwd_data_o == expv) else begin
                $display("[ERROR] %s: fwd valid/rd/data expected 1/%0d/%h actual %b/%0d/%h",
                         cur_test, s + 1, expv, fwd_valid_o, fwd_rd_o, fwd_data_o);
                errors++;
            end
        end
        wait_drain();
        end_test();

        start_test("back_pressure");
        fixed_timing  = 1'b0;
        r             = rand_bits(32);
        ready_pattern = r | 32'h5555_5555;
        stall_mode    = 1'b1;
        for (int i = 0; i < 24; i++) begin
            r     = rand_bits(13);
            width = pick_width(r[8:6]);
            addr  = {26'h0, r[5:2], aligned_offset(width, r[10:9])};
            case (r[1:0])
                2'd0: send_item(addr, rand_bits(32), 5'd0, width,
                                rv_mem_pkg::RESULT_ALU, 1'b1, 1'b0, expv);
                2'd1: send_item(addr, 32'h0, r[6:2], width,
                                rv_mem_pkg::RESULT_MEM, 1'b0, 1'b1, expv);
                default: send_item(rand_bits(32), 32'h0, r[12:8], rv_mem_pkg::WIDTH_W,
                                   pick_src(r[12:11]), 1'b0, 1'b1, expv);
            endcase
            if (lfsr_bit()) begin
                idle_cycle();
            end
        end
        wait_drain();
        end_test();

        // Stores issued under stall read back word by word
        start_test("stall_readback");
        for (int w = 0; w < 16; w++) begin
            r = rand_bits(5);
            send_item(32'(w) * 4, 32'h0, r[4:0], rv_mem_pkg::WIDTH_W,
                      rv_mem_pkg::RESULT_MEM, 1'b0, 1'b1, expv);
        end
        wait_drain();
        stall_mode = 1'b0;
        repeat (4) @(negedge clk_i);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_DEPTH_WORDS = 256
) (
    input logic   clk_i,
    dmem_if.slave mem
);

    localparam int ADDR_W = $clog2(MEM_DEPTH_WORDS);

    logic [rv_mem_pkg::XLEN-1:0] ram [MEM_DEPTH_WORDS];
    logic [ADDR_W-1:0]           word_idx;

    // Index wraps within the array
    assign word_idx = mem.addr[ADDR_W-1:0];

    // Asynchronous read
    assign mem.rdata = ram[word_idx];

    // Byte-lane write
    always_ff @(posedge clk_i) begin
        if (mem.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem.byte_en[lane]) begin
                    ram[word_idx][lane*8 +: 8] <= mem.wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

// File: src/load_reduce.sv
`timescale 1ns/1ps

module load_reduce (
    input  logic [1:0]                  addr_lo_i,
    input  rv_mem_pkg::width_src_e      width_i,
    input  logic [rv_mem_pkg::XLEN-1:0] word_i,
    output logic [rv_mem_pkg::XLEN-1:0] data_o
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Lane picked by the low address bits
    always_comb begin
        case (addr_lo_i)
            2'd0:    sel_byte = word_i[7:0];
            2'd1:    sel_byte = word_i[15:8];
            2'd2:    sel_byte = word_i[23:16];
            default: sel_byte = word_i[31:24];
        endcase
    end

    assign sel_half = addr_lo_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (width_i)
            rv_mem_pkg::WIDTH_B: begin
                data_o = {{(rv_mem_pkg::XLEN-8){sel_byte[7]}}, sel_byte};
            end
            rv_mem_pkg::WIDTH_H: begin
                data_o = {{(rv_mem_pkg::XLEN-16){sel_half[15]}}, sel_half};
            end
            rv_mem_pkg::WIDTH_BU: begin
                data_o = {{(rv_mem_pkg::XLEN-8){1'b0}}, sel_byte};
            end
            rv_mem_pkg::WIDTH_HU: begin
                data_o = {{(rv_mem_pkg::XLEN-16){1'b0}}, sel_half};
            end
            default: data_o = word_i;
        endcase
    end

endmodule

// File: src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int MEM_DEPTH_WORDS = 256
) (
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Execute-stage input
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  logic [rv_mem_pkg::XLEN-1:0] in_alu_result_i,
    input  logic [rv_mem_pkg::XLEN-1:0] in_write_data_i,
    input  logic [rv_mem_pkg::XLEN-1:0] in_pc_target_i,
    input  logic [rv_mem_pkg::XLEN-1:0] in_pc_plus4_i,
    input  logic [rv_mem_pkg::XLEN-1:0] in_imm_ext_i,
    input  logic [4:0]                  in_rd_i,
    input  rv_mem_pkg::width_src_e      in_width_src_i,
    input  rv_mem_pkg::result_src_e     in_result_src_i,
    input  logic                        in_mem_write_i,
    input  logic                        in_reg_write_i,

    // Forwarding from M
    output logic                        fwd_valid_o,
    output logic [4:0]                  fwd_rd_o,
    output logic [rv_mem_pkg::XLEN-1:0] fwd_data_o,

    // Write-back output
    output logic                        wb_valid_o,
    input  logic                        wb_ready_i,
    output logic [4:0]                  wb_rd_o,
    output logic [rv_mem_pkg::XLEN-1:0] wb_data_o,
    output logic                        wb_reg_write_o
);

    exmem_if ex_bus ();
    memwb_if mw_bus ();
    dmem_if  dmem_bus ();

    assign ex_bus.valid      = in_valid_i;
    assign ex_bus.alu_result = in_alu_result_i;
    assign ex_bus.write_data = in_write_data_i;
    assign ex_bus.pc_target  = in_pc_target_i;
    assign ex_bus.pc_plus4   = in_pc_plus4_i;
    assign ex_bus.imm_ext    = in_imm_ext_i;
    assign ex_bus.rd         = in_rd_i;
    assign ex_bus.width_src  = in_width_src_i;
    assign ex_bus.result_src = in_result_src_i;
    assign ex_bus.mem_write  = in_mem_write_i;
    assign ex_bus.reg_write  = in_reg_write_i;
    assign in_ready_o        = ex_bus.ready;

    memory_stage #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) memory_stage_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ex          (ex_bus.slave),
        .wb          (mw_bus.master),
        .dmem        (dmem_bus.master),
        .fwd_valid_o (fwd_valid_o),
        .fwd_rd_o    (fwd_rd_o),
        .fwd_data_o  (fwd_data_o)
    );

    writeback_stage writeback_stage_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .mw             (mw_bus.slave),
        .wb_ready_i     (wb_ready_i),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_reg_write_o (wb_reg_write_o)
    );

    data_mem #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) data_mem_inst (
        .clk_i (clk_i),
        .mem   (dmem_bus.slave)
    );

endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int MEM_DEPTH_WORDS = 256
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    exmem_if.slave                      ex,
    memwb_if.master                     wb,
    dmem_if.master                      dmem,
    output logic                        fwd_valid_o,
    output logic [4:0]                  fwd_rd_o,
    output logic [rv_mem_pkg::XLEN-1:0] fwd_data_o
);

    localparam int ADDR_W = $clog2(MEM_DEPTH_WORDS);

    logic                         m_valid;
    logic [rv_mem_pkg::XLEN-1:0]  m_alu_result;
    logic [rv_mem_pkg::XLEN-1:0]  m_write_data;
    logic [rv_mem_pkg::XLEN-1:0]  m_pc_target;
    logic [rv_mem_pkg::XLEN-1:0]  m_pc_plus4;
    logic [rv_mem_pkg::XLEN-1:0]  m_imm_ext;
    logic [4:0]                   m_rd;
    rv_mem_pkg::width_src_e       m_width_src;
    rv_mem_pkg::result_src_e      m_result_src;
    logic                         m_mem_write;
    logic                         m_reg_write;
    logic                         m_leaving;
    logic [rv_mem_pkg::XLEN-1:0]  fwd_data;

    assign m_leaving = m_valid && wb.ready;
    // Accept when empty or draining this cycle
    assign ex.ready  = !m_valid || wb.ready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            m_valid <= 1'b0;
        end else if (ex.ready) begin
            m_valid <= ex.valid;
        end
    end

    // E/M payload registers
    always_ff @(posedge clk_i) begin
        if (ex.valid && ex.ready) begin
            m_alu_result <= ex.alu_result;
            m_write_data <= ex.write_data;
            m_pc_target  <= ex.pc_target;
            m_pc_plus4   <= ex.pc_plus4;
            m_imm_ext    <= ex.imm_ext;
            m_rd         <= ex.rd;
            m_width_src  <= ex.width_src;
            m_result_src <= ex.result_src;
            m_mem_write  <= ex.mem_write;
            m_reg_write  <= ex.reg_write;
        end
    end

    // Word index from the byte address
    assign dmem.addr = {{(rv_mem_pkg::XLEN-ADDR_W){1'b0}}, m_alu_result[ADDR_W+1:2]};
    // Write only on the departing cycle so a held store hits memory once
    assign dmem.we   = m_leaving && m_mem_write;

    store_align store_align_inst (
        .addr_lo_i (m_alu_result[1:0]),
        .width_i   (m_width_src),
        .data_i    (m_write_data),
        .wdata_o   (dmem.wdata),
        .byte_en_o (dmem.byte_en)
    );

    load_reduce load_reduce_inst (
        .addr_lo_i (m_alu_result[1:0]),
        .width_i   (m_width_src),
        .word_i    (dmem.rdata),
        .data_o    (wb.load_data)
    );

    // Forwarding mux gives zero for loads
    always_comb begin
        case (m_result_src)
            rv_mem_pkg::RESULT_ALU:      fwd_data = m_alu_result;
            rv_mem_pkg::RESULT_PCTARGET: fwd_data = m_pc_target;
            rv_mem_pkg::RESULT_PCPLUS4:  fwd_data = m_pc_plus4;
            rv_mem_pkg::RESULT_IMM_EXT:  fwd_data = m_imm_ext;
            default:                     fwd_data = '0;
        endcase
    end

    assign wb.valid      = m_valid;
    assign wb.fwd_data   = fwd_data;
    assign wb.rd         = m_rd;
    assign wb.result_src = m_result_src;
    assign wb.reg_write  = m_reg_write;

    assign fwd_valid_o = m_valid && m_reg_write;
    assign fwd_rd_o    = m_rd;
    assign fwd_data_o  = fwd_data;

endmodule

// File: src/rv_mem_ifs.sv
`timescale 1ns/1ps

// Execute to memory stage
interface exmem_if;
    logic                         valid;
    logic                         ready;
    logic [rv_mem_pkg::XLEN-1:0]  alu_result;
    logic [rv_mem_pkg::XLEN-1:0]  write_data;
    logic [rv_mem_pkg::XLEN-1:0]  pc_target;
    logic [rv_mem_pkg::XLEN-1:0]  pc_plus4;
    logic [rv_mem_pkg::XLEN-1:0]  imm_ext;
    logic [4:0]                   rd;
    rv_mem_pkg::width_src_e       width_src;
    rv_mem_pkg::result_src_e      result_src;
    logic                         mem_write;
    logic                         reg_write;

    modport master (
        output valid, alu_result, write_data, pc_target, pc_plus4, imm_ext,
        output rd, width_src, result_src, mem_write, reg_write,
        input  ready
    );
    modport slave (
        input  valid, alu_result, write_data, pc_target, pc_plus4, imm_ext,
        input  rd, width_src, result_src, mem_write, reg_write,
        output ready
    );
endinterface

// Memory to write-back stage
interface memwb_if;
    logic                         valid;
    logic                         ready;
    logic [rv_mem_pkg::XLEN-1:0]  fwd_data;
    logic [rv_mem_pkg::XLEN-1:0]  load_data;
    logic [4:0]                   rd;
    rv_mem_pkg::result_src_e      result_src;
    logic                         reg_write;

    modport master (output valid, fwd_data, load_data, rd, result_src, reg_write, input ready);
    modport slave  (input valid, fwd_data, load_data, rd, result_src, reg_write, output ready);
endinterface

// Memory stage to data RAM, addr is a word index
interface dmem_if;
    logic [rv_mem_pkg::XLEN-1:0]  addr;
    logic [rv_mem_pkg::XLEN-1:0]  wdata;
    logic [3:0]                   byte_en;
    logic                         we;
    logic [rv_mem_pkg::XLEN-1:0]  rdata;

    modport master (output addr, wdata, byte_en, we, input rdata);
    modport slave  (input addr, wdata, byte_en, we, output rdata);
endinterface

// File: src/rv_mem_pkg.sv
package rv_mem_pkg;

    // Data and address width
    parameter int XLEN = 32;

    // Source of the value written back to the register file
    typedef enum logic [2:0] {
        RESULT_ALU      = 3'b000,
        RESULT_MEM      = 3'b001,
        RESULT_PCTARGET = 3'b010,
        RESULT_PCPLUS4  = 3'b011,
        RESULT_IMM_EXT  = 3'b100
    } result_src_e;

    // Access width, encoded as the RV32 load/store funct3
    typedef enum logic [2:0] {
        WIDTH_B  = 3'b000,
        WIDTH_H  = 3'b001,
        WIDTH_W  = 3'b010,
        WIDTH_BU = 3'b100,
        WIDTH_HU = 3'b101
    } width_src_e;

endpackage

// File: src/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic [1:0]                  addr_lo_i,
    input  rv_mem_pkg::width_src_e      width_i,
    input  logic [rv_mem_pkg::XLEN-1:0] data_i,
    output logic [rv_mem_pkg::XLEN-1:0] wdata_o,
    output logic [3:0]                  byte_en_o
);

    always_comb begin
        case (width_i)
            // Byte copied to all lanes, one lane enabled
            rv_mem_pkg::WIDTH_B,
            rv_mem_pkg::WIDTH_BU: begin
                wdata_o   = {4{data_i[7:0]}};
                byte_en_o = 4'b0001 << addr_lo_i;
            end
            // Half copied to both halves
            rv_mem_pkg::WIDTH_H,
            rv_mem_pkg::WIDTH_HU: begin
                wdata_o = {2{data_i[15:0]}};
                if (addr_lo_i[1]) begin
                    byte_en_o = 4'b1100;
                end else begin
                    byte_en_o = 4'b0011;
                end
            end
            default: begin
                wdata_o   = data_i;
                byte_en_o = 4'b1111;
            end
        endcase
    end

endmodule

// File: src/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    memwb_if.slave                      mw,
    input  logic                        wb_ready_i,
    output logic                        wb_valid_o,
    output logic [4:0]                  wb_rd_o,
    output logic [rv_mem_pkg::XLEN-1:0] wb_data_o,
    output logic                        wb_reg_write_o
);

    logic                         w_valid;
    logic [4:0]                   w_rd;
    logic [rv_mem_pkg::XLEN-1:0]  w_data;
    logic                         w_reg_write;
    logic [rv_mem_pkg::XLEN-1:0]  result;

    // Final result chosen on the way in
    assign result = (mw.result_src == rv_mem_pkg::RESULT_MEM) ? mw.load_data : mw.fwd_data;

    // Free when empty or when the consumer takes the item
    assign mw.ready = !w_valid || wb_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            w_valid <= 1'b0;
        end else if (mw.ready) begin
            w_valid <= mw.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mw.valid && mw.ready) begin
            w_rd        <= mw.rd;
            w_data      <= result;
            w_reg_write <= mw.reg_write;
        end
    end

    assign wb_valid_o     = w_valid;
    assign wb_rd_o        = w_rd;
    assign wb_data_o      = w_data;
    assign wb_reg_write_o = w_reg_write;

endmodule
